// File: video_macros.svh
`ifndef VIDEO_MACROS_SVH
`define VIDEO_MACROS_SVH

// Raster timing. The numbers are tiny so that a whole frame is short.
`define H_TOTAL 40
`define H_VISIBLE 32
`define H_SYNC_START 34
`define H_SYNC_WIDTH 3

`define V_TOTAL 12
`define V_TOTAL_ADDED 13 // One extra line when add_line is set.
`define V_VISIBLE 8
`define V_SYNC_START 9
`define V_SYNC_WIDTH 2

// Both syncs are active low.
`define H_SYNC_ACTIVE 1'b0
`define V_SYNC_ACTIVE 1'b0

// Line buffer geometry.
`define BUF_ADDR_WIDTH 8
`define BLANK_ADDR 255 // Read while the column is outside the visible part.

`endif

// File: video_pkg.sv
`default_nettype none
`include "video_macros.svh"

package video_pkg;

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

	typedef struct packed {
		logic [11:0] column;
		logic [11:0] line;
	} raster_pos_t;

	typedef struct packed {
		logic line_doubler;
		logic add_line;
	} video_mode_t;

	// One buffer write, taken on a single-cycle strobe.
	typedef struct packed {
		logic [`BUF_ADDR_WIDTH-1:0] address;
		rgb_t colour;
	} pixel_write_t;

	typedef struct packed {
		rgb_t colour;
		logic hsync;
		logic vsync;
		logic draw_area;
	} video_pixel_t;

	typedef enum logic {
		TIMING_IDLE,
		TIMING_RUN
	} timing_state_e;

endpackage

`default_nettype wire

// File: raster_timing.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module raster_timing (
	input wire logic clock,
	input wire logic reset,
	input wire logic start_strobe,
	input wire video_pkg::video_mode_t mode,
	output video_pkg::raster_pos_t position,
	output logic active
);

	localparam logic [11:0] COLUMN_LAST = 12'(`H_TOTAL - 1);
	localparam logic [11:0] LINE_LAST = 12'(`V_TOTAL - 1);
	localparam logic [11:0] LINE_LAST_ADDED = 12'(`V_TOTAL_ADDED - 1);

	video_pkg::timing_state_e state;
	video_pkg::video_mode_t mode_q;
	logic [11:0] column;
	logic [11:0] line;
	logic [11:0] line_last;
	logic mode_changed;

	assign mode_changed = (mode != mode_q);
	assign line_last = mode_q.add_line ? LINE_LAST_ADDED : LINE_LAST;

	always_ff @(posedge clock) begin
		if (!reset) begin
			state <= video_pkg::TIMING_IDLE;
			mode_q <= '0;
			column <= '0;
			line <= '0;
		end else begin
			mode_q <= mode;
			if (mode_changed) begin
				// Any change of mode drops the raster until the next start.
				state <= video_pkg::TIMING_IDLE;
				column <= '0;
				line <= '0;
			end else begin
				case (state)
					video_pkg::TIMING_IDLE: begin
						if (start_strobe) begin
							state <= video_pkg::TIMING_RUN; // Counters are already at zero.
						end
					end
					video_pkg::TIMING_RUN: begin
						if (column == COLUMN_LAST) begin
							column <= '0;
							if (line == line_last) begin
								line <= '0;
							end else begin
								line <= line + 12'd1;
							end
						end else begin
							column <= column + 12'd1;
						end
					end
					default: begin
						state <= video_pkg::TIMING_IDLE;
					end
				endcase
			end
		end
	end

	always_comb begin
		position.column = column;
		position.line = line;
	end

	assign active = (state == video_pkg::TIMING_RUN); // Start strobes are ignored here.

	column_in_range: assert property (
		@(posedge clock) disable iff (!reset)
		column < 12'(`H_TOTAL)
	);

	// Holds across a change of add_line too, since that change clears the line.
	line_in_range: assert property (
		@(posedge clock) disable iff (!reset)
		line <= line_last
	);

endmodule

`default_nettype wire

// File: line_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module line_buffer (
	input wire logic clock,
	input wire logic write_strobe,
	input wire video_pkg::pixel_write_t write_pixel,
	input wire logic [`BUF_ADDR_WIDTH-1:0] read_address,
	output video_pkg::rgb_t read_data
);

	localparam int DEPTH = 2 ** `BUF_ADDR_WIDTH;

	video_pkg::rgb_t memory [DEPTH];

	// Write port.
	always_ff @(posedge clock) begin
		if (write_strobe) begin
			memory[write_pixel.address] <= write_pixel.colour;
		end
	end

	// Registered read port.
	// A read of the word being written in the same cycle sees the old contents.
	always_ff @(posedge clock) begin
		read_data <= memory[read_address];
	end

endmodule

`default_nettype wire

// File: pixel_fetch.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module pixel_fetch (
	input wire logic clock,
	input wire logic reset,
	input wire video_pkg::raster_pos_t position,
	input wire logic active,
	input wire logic line_doubler,
	input wire video_pkg::rgb_t read_data,
	output logic [`BUF_ADDR_WIDTH-1:0] read_address,
	output video_pkg::video_pixel_t pixel
);

	localparam logic [11:0] H_SYNC_END = 12'(`H_SYNC_START + `H_SYNC_WIDTH);
	localparam logic [11:0] V_SYNC_END = 12'(`V_SYNC_START + `V_SYNC_WIDTH);

	video_pkg::raster_pos_t position_q;
	logic active_q;
	logic in_hsync;
	logic in_vsync;
	logic in_draw;

	// Address mapping for the position presented in this cycle.
	always_comb begin
		if (position.column >= 12'(`H_VISIBLE)) begin
			read_address = `BUF_ADDR_WIDTH'(`BLANK_ADDR);
		end else if (line_doubler) begin
			// Two line bits pick one of four stored lines.
			read_address = {position.line[2:1], position.column[`BUF_ADDR_WIDTH-3:0]};
		end else begin
			read_address = position.column[`BUF_ADDR_WIDTH-1:0];
		end
	end

	// First stage runs alongside the buffer read.
	always_ff @(posedge clock) begin
		if (!reset) begin
			active_q <= 1'b0;
		end else begin
			active_q <= active;
		end
	end

	always_ff @(posedge clock) begin
		position_q <= position;
	end

	assign in_hsync = (position_q.column >= 12'(`H_SYNC_START)) && (position_q.column < H_SYNC_END);
	assign in_vsync = (position_q.line >= 12'(`V_SYNC_START)) && (position_q.line < V_SYNC_END);
	assign in_draw = (position_q.column < 12'(`H_VISIBLE)) && (position_q.line < 12'(`V_VISIBLE));

	// Output register. Everything leaves two cycles after the position.
	always_ff @(posedge clock) begin
		if (!reset || !active_q) begin
			pixel.colour <= '0;
			pixel.hsync <= ~`H_SYNC_ACTIVE;
			pixel.vsync <= ~`V_SYNC_ACTIVE;
			pixel.draw_area <= 1'b0;
		end else begin
			pixel.colour <= in_draw ? read_data : '0; // Black outside the picture.
			pixel.hsync <= in_hsync ? `H_SYNC_ACTIVE : ~`H_SYNC_ACTIVE;
			pixel.vsync <= in_vsync ? `V_SYNC_ACTIVE : ~`V_SYNC_ACTIVE;
			pixel.draw_area <= in_draw;
		end
	end

	// draw_area may only rise on a pixel whose position came from a running raster.
	draw_needs_active: assert property (
		@(posedge clock) disable iff (!reset)
		$rose(pixel.draw_area) |-> $past(active_q)
	);

endmodule

`default_nettype wire

// File: video_out.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_out (
	input wire logic clock,
	input wire logic reset,
	input wire logic write_strobe,
	input wire video_pkg::pixel_write_t write_pixel,
	input wire logic start_strobe,
	input wire video_pkg::video_mode_t mode,
	output video_pkg::video_pixel_t pixel
);

	video_pkg::raster_pos_t position;
	video_pkg::rgb_t read_data;
	logic active;
	logic [`BUF_ADDR_WIDTH-1:0] read_address;

	raster_timing u_raster_timing (
		.clock(clock),
		.reset(reset),
		.start_strobe(start_strobe),
		.mode(mode),
		.position(position),
		.active(active)
	);

	// Reads and writes share the pixel clock.
	line_buffer u_line_buffer (
		.clock(clock),
		.write_strobe(write_strobe),
		.write_pixel(write_pixel),
		.read_address(read_address),
		.read_data(read_data)
	);

	pixel_fetch u_pixel_fetch (
		.clock(clock),
		.reset(reset),
		.position(position),
		.active(active),
		.line_doubler(mode.line_doubler),
		.read_data(read_data),
		.read_address(read_address),
		.pixel(pixel)
	);

endmodule

`default_nettype wire

// File: video_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module video_clock_gen #(
	parameter int HALF_PERIOD_NS = 2,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic reset
);

	initial begin
		clock = 1'b0;
		forever #(HALF_PERIOD_NS) clock = ~clock;
	end

	// Reset is active low and is released just after the last reset edge.
	initial begin
		reset = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1 reset = 1'b1;
	end

endmodule

`default_nettype wire

// File: video_out_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "video_macros.svh"

module video_out_tb;

	localparam int BUF_DEPTH = 2 ** `BUF_ADDR_WIDTH;
	localparam int CYCLE_LIMIT = 6 * `V_TOTAL_ADDED * `H_TOTAL + 200;

	logic clock;
	logic reset;
	logic write_strobe;
	video_pkg::pixel_write_t write_pixel;
	logic start_strobe;
	video_pkg::video_mode_t mode;
	video_pkg::video_pixel_t pixel;

	video_pkg::rgb_t mem_copy [BUF_DEPTH];
	video_pkg::raster_pos_t model_pos;
	video_pkg::video_mode_t model_mode_q;
	logic model_running;
	video_pkg::video_pixel_t expected_in_read; // Position whose buffer read is under way.
	video_pkg::video_pixel_t expected_out;
	int cycle_count = 0;
	int checks_done = 0;
	int error_count = 0;

	video_clock_gen clock_gen (.clock(clock), .reset(reset));

	video_out dut (
		.clock(clock),
		.reset(reset),
		.write_strobe(write_strobe),
		.write_pixel(write_pixel),
		.start_strobe(start_strobe),
		.mode(mode),
		.pixel(pixel)
	);

	function automatic video_pkg::video_pixel_t idle_pixel();
		video_pkg::video_pixel_t result;
		result.colour = '0;
		result.hsync = ~`H_SYNC_ACTIVE;
		result.vsync = ~`V_SYNC_ACTIVE;
		result.draw_area = 1'b0;
		return result;
	endfunction

	function automatic video_pkg::video_pixel_t expected_pixel(
		input video_pkg::raster_pos_t pos,
		input logic running,
		input video_pkg::video_mode_t mode_now
	);
		video_pkg::video_pixel_t result;
		logic [`BUF_ADDR_WIDTH-1:0] address;
		logic in_hsync;
		logic in_vsync;
		result = idle_pixel();
		if (running) begin
			in_hsync = pos.column >= `H_SYNC_START && pos.column < `H_SYNC_START + `H_SYNC_WIDTH;
			in_vsync = pos.line >= `V_SYNC_START && pos.line < `V_SYNC_START + `V_SYNC_WIDTH;
			result.hsync = in_hsync ? `H_SYNC_ACTIVE : ~`H_SYNC_ACTIVE;
			result.vsync = in_vsync ? `V_SYNC_ACTIVE : ~`V_SYNC_ACTIVE;
			result.draw_area = pos.column < `H_VISIBLE && pos.line < `V_VISIBLE;
			if (pos.column >= `H_VISIBLE) begin
				address = `BUF_ADDR_WIDTH'(`BLANK_ADDR);
			end else if (mode_now.line_doubler) begin
				address = {pos.line[2:1], pos.column[5:0]};
			end else begin
				address = pos.column[`BUF_ADDR_WIDTH-1:0];
			end
			result.colour = result.draw_area ? mem_copy[address] : '0;
		end
		return result;
	endfunction

	function automatic video_pkg::rgb_t random_colour();
		logic [31:0] bits;
		bits = $urandom;
		return bits[23:0];
	endfunction

	task automatic check_pixel(input video_pkg::video_pixel_t actual,
			input video_pkg::video_pixel_t expected, input string what);
		checks_done = checks_done + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("FAILED at %0t: %s: got %h/%b%b%b, expected %h/%b%b%b", $time, what,
				actual.colour, actual.hsync, actual.vsync, actual.draw_area,
				expected.colour, expected.hsync, expected.vsync, expected.draw_area);
		end
	endtask

	task automatic check_idle(input video_pkg::video_pixel_t actual, input string what);
		check_pixel(actual, idle_pixel(), what);
	endtask

	task automatic check_cycles(input string what, input int actual, input int expected);
		checks_done = checks_done + 1;
		if (actual != expected) begin
			error_count = error_count + 1;
			$display("FAILED at %0t: %s: got %0d cycles, expected %0d", $time, what,
				actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks_done, error_count);
		if (error_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#1;
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) next_cycle();
	endtask

	task automatic pulse_start();
		start_strobe = 1'b1;
		next_cycle();
		start_strobe = 1'b0;
	endtask

	// Returns the cycle on which the output vsync turns active.
	task automatic wait_vsync_start(output int at_cycle);
		logic previous;
		previous = pixel.vsync;
		next_cycle();
		while (!(previous != `V_SYNC_ACTIVE && pixel.vsync == `V_SYNC_ACTIVE)) begin
			previous = pixel.vsync;
			next_cycle();
		end
		at_cycle = cycle_count;
	endtask

	// Model of the raster, the buffer and the two pipeline stages.
	always @(posedge clock) begin : raster_model
		int line_count;
		if (!reset) begin
			model_running = 1'b0;
			model_pos = '0;
			model_mode_q = '0;
			expected_in_read = idle_pixel();
			expected_out = idle_pixel();
		end else begin
			expected_out = expected_in_read;
			expected_in_read = expected_pixel(model_pos, model_running, mode); // Old buffer word.
			if (write_strobe) begin
				mem_copy[write_pixel.address] = write_pixel.colour;
			end
			line_count = model_mode_q.add_line ? `V_TOTAL_ADDED : `V_TOTAL;
			if (mode != model_mode_q) begin
				model_running = 1'b0;
				model_pos = '0;
			end else if (!model_running) begin
				model_running = start_strobe;
			end else if (model_pos.column == `H_TOTAL - 1) begin
				model_pos.column = '0;
				model_pos.line = (model_pos.line == line_count - 1) ? '0 : model_pos.line + 12'd1;
			end else begin
				model_pos.column = model_pos.column + 12'd1;
			end
			model_mode_q = mode;
		end
	end

	always @(negedge clock) begin
		check_pixel(pixel, expected_out, "pixel output");
	end

	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
			error_count = error_count + 1;
			finish_run();
		end
	end

	initial begin
		int first_start;
		int second_start;
		int normal_period;
		int added_period;
		int latency;
		video_pkg::raster_pos_t origin;
		write_strobe = 1'b0;
		write_pixel = '0;
		start_strobe = 1'b0;
		mode = '0;
		origin = '0;
		void'($urandom(32'hc2b8_ce25));
		wait (reset === 1'b1);
		next_cycle();
		repeat (5) begin
			check_idle(pixel, "idle after reset");
			next_cycle();
		end

		for (int a = 0; a < BUF_DEPTH; a++) begin
			write_pixel.address = `BUF_ADDR_WIDTH'(a);
			write_pixel.colour = random_colour();
			write_strobe = 1'b1;
			next_cycle();
		end
		write_strobe = 1'b0;
		check_idle(pixel, "idle after buffer fill");

		// Normal mode over a whole frame.
		pulse_start();
		wait_vsync_start(first_start);
		wait_vsync_start(second_start);
		normal_period = second_start - first_start;
		check_cycles("normal vsync period", normal_period, `V_TOTAL * `H_TOTAL);

		mode.line_doubler = 1'b1;
		wait_cycles(3);
		check_idle(pixel, "idle after switch to line doubler");
		pulse_start();
		wait_vsync_start(first_start);

		// Added line, with writes and an extra start strobe in vertical blanking.
		mode = '0;
		mode.add_line = 1'b1;
		wait_cycles(3);
		check_idle(pixel, "idle after switch to added line");
		pulse_start();
		wait_vsync_start(first_start);
		for (int a = 0; a < `H_VISIBLE; a++) begin
			write_pixel.address = `BUF_ADDR_WIDTH'(a);
			write_pixel.colour = random_colour();
			write_strobe = 1'b1;
			start_strobe = (a == 10);
			next_cycle();
		end
		write_strobe = 1'b0;
		start_strobe = 1'b0;
		wait_vsync_start(second_start);
		added_period = second_start - first_start;
		check_cycles("added-line vsync period", added_period, `V_TOTAL_ADDED * `H_TOTAL);
		check_cycles("vsync period growth", added_period - normal_period, `H_TOTAL);

		// Mode change in the visible part of the next frame.
		wait_cycles(200);
		mode = '0;
		wait_cycles(3);
		repeat (20) begin
			check_idle(pixel, "idle after mid-frame mode change");
			next_cycle();
		end
		pulse_start();
		latency = 0;
		while (pixel.draw_area !== 1'b1) begin
			next_cycle();
			latency = latency + 1;
		end
		check_cycles("first pixel after restart", latency, 2);
		check_pixel(pixel, expected_pixel(origin, 1'b1, mode), "restart at column 0, line 0");
		wait_vsync_start(first_start);
		wait_cycles(2);
		finish_run();
	end

endmodule

`default_nettype wire

// File: video_out.f
+incdir+.
video_pkg.sv
raster_timing.sv
line_buffer.sv
pixel_fetch.sv
video_out.sv
video_clock_gen.sv
video_out_tb.sv
